//--- hdl/core_config.svh
// Build-time sizes for the core. Memory depths must be powers of two.
// Addresses beyond a memory's depth wrap onto the low words.

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Instruction memory depth in 32-bit words
`define CORE_IMEM_WORDS 256

// Data memory depth in 32-bit words
`define CORE_DMEM_WORDS 256

// First pc after reset, byte address
`define CORE_RESET_PC 32'h0000_0000

`endif

//--- hdl/core_pkg.sv
// Shared types for the three-stage RV32I subset core.
// Only the opcodes listed in opcode_e are decoded.

`default_nettype none

package core_pkg;

  //--------------------------------------------------------------------
  // Basic widths
  //--------------------------------------------------------------------

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  //--------------------------------------------------------------------
  // Major opcodes, inst[6:0]
  //--------------------------------------------------------------------

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // ALU function, PASS_B forwards operand b (lui)
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_PASS_B
  } alu_op_e;

  // Source of the value written back
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_LINK
  } wb_sel_e;

endpackage

`default_nettype wire

//--- hdl/word_mem.sv
// Word-wide RAM with one registered read port and one write port.
// addr is a word index; bits above log2(DEPTH) are ignored.
// A read of a word written in the same cycle returns the old value.

`timescale 1ns/1ps
`default_nettype none

module word_mem
  import core_pkg::*;
#(
  parameter int DEPTH = 256
) (
  input  logic  clk,
  input  word_t addr,
  output word_t rd_data,
  input  logic  wr_en,
  input  word_t wr_data
);

  localparam int AW = $clog2(DEPTH);

  // Storage, no reset
  word_t            mem [DEPTH];
  logic  [AW-1:0]   idx;

  // Upper address bits wrap
  assign idx = addr[AW-1:0];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[idx] <= wr_data;
    end
    // Read every cycle, old data on collision
    rd_data <= mem[idx];
  end

endmodule

`default_nettype wire

//--- hdl/regfile.sv
// Integer register file, x1..x31 stored, x0 reads as zero.
// Reads are combinational and see the old value during a write.

`timescale 1ns/1ps
`default_nettype none

module regfile
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      we,
  input  reg_addr_t rd,
  input  word_t     rd_data
);

  word_t regs [1:31];

  // x0 never stored
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
// Program counter and fetch valid tracking.
// pc goes straight to the instruction memory; the word shows up next cycle.
// A redirect wins over the sequential step and kills the word in flight.

`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module fetch_stage
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  run,
  input  logic  redirect,
  input  word_t target,
  output word_t pc,
  output logic  x_valid,
  output word_t x_pc
);

  //--------------------------------------------------------------------
  // PC register
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `CORE_RESET_PC;
    end else if (redirect) begin
      // Branch or jump resolved in execute
      pc <= target;
    end else if (run) begin
      pc <= pc + 32'd4;
    end
  end

  //--------------------------------------------------------------------
  // Execute-side tag for the word now leaving memory
  //--------------------------------------------------------------------

  // Live only if fetched while running and not behind a redirect
  always_ff @(posedge clk) begin
    if (rst) begin
      x_valid <= 1'b0;
    end else begin
      x_valid <= run && !redirect;
    end
  end

  // pc that went with the memory read
  always_ff @(posedge clk) begin
    x_pc <= pc;
  end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
// Decode, operand bypass, ALU, beq/jal resolution and data memory issue.
// Encodings outside add/sub/and/or/addi/lui/lw/sw/beq/jal retire as no-ops.
// dmem_addr is a byte address; the low two bits are not checked.

`timescale 1ns/1ps
`default_nettype none

module execute_stage
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      x_valid,
  input  word_t     x_pc,
  input  word_t     inst,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  input  logic      byp_we,
  input  reg_addr_t byp_rd,
  input  word_t     byp_data,
  output word_t     dmem_addr,
  output logic      dmem_we,
  output word_t     dmem_wdata,
  output logic      redirect,
  output word_t     target,
  output logic      w_valid,
  output word_t     w_pc,
  output reg_addr_t w_rd,
  output logic      w_we,
  output wb_sel_e   w_sel,
  output word_t     w_alu
);

  //--------------------------------------------------------------------
  // Instruction fields
  //--------------------------------------------------------------------

  opcode_e    opcode;
  reg_addr_t  rd;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = opcode_e'(inst[6:0]);
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  // Sign-extended immediates per format
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  //--------------------------------------------------------------------
  // Operands, writeback value wins on a match
  //--------------------------------------------------------------------

  word_t src_a;
  word_t src_b;

  // Covers load results too, so no load-use stall
  assign src_a = (byp_we && byp_rd != '0 && byp_rd == rs1) ? byp_data : rs1_data;
  assign src_b = (byp_we && byp_rd != '0 && byp_rd == rs2) ? byp_data : rs2_data;

  //--------------------------------------------------------------------
  // Control decode
  //--------------------------------------------------------------------

  alu_op_e alu_op;
  wb_sel_e sel;
  word_t   imm;
  logic    use_imm;
  logic    rd_we;
  logic    is_store;
  logic    is_beq;
  logic    is_jal;

  always_comb begin
    alu_op   = ALU_ADD;
    sel      = WB_ALU;
    imm      = imm_i;
    use_imm  = 1'b0;
    rd_we    = 1'b0;
    is_store = 1'b0;
    is_beq   = 1'b0;
    is_jal   = 1'b0;
    case (opcode)
      OPC_OP: begin
        rd_we = 1'b1;
        case (funct3)
          3'b000:  alu_op = inst[30] ? ALU_SUB : ALU_ADD;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: rd_we = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        // addi only
        use_imm = 1'b1;
        rd_we   = (funct3 == 3'b000);
      end
      OPC_LUI: begin
        alu_op  = ALU_PASS_B;
        imm     = imm_u;
        use_imm = 1'b1;
        rd_we   = 1'b1;
      end
      OPC_LOAD: begin
        // lw, address = rs1 + imm
        use_imm = 1'b1;
        sel     = WB_LOAD;
        rd_we   = (funct3 == 3'b010);
      end
      OPC_STORE: begin
        imm      = imm_s;
        use_imm  = 1'b1;
        is_store = (funct3 == 3'b010);
      end
      OPC_BRANCH: is_beq = (funct3 == 3'b000);
      OPC_JAL: begin
        // Link value formed in writeback
        sel    = WB_LINK;
        rd_we  = 1'b1;
        is_jal = 1'b1;
      end
      default: ;
    endcase
  end

  //--------------------------------------------------------------------
  // ALU
  //--------------------------------------------------------------------

  word_t alu_b;
  word_t alu_y;

  assign alu_b = use_imm ? imm : src_b;

  always_comb begin
    case (alu_op)
      ALU_ADD: alu_y = src_a + alu_b;
      ALU_SUB: alu_y = src_a - alu_b;
      ALU_AND: alu_y = src_a & alu_b;
      ALU_OR:  alu_y = src_a | alu_b;
      default: alu_y = alu_b;
    endcase
  end

  //--------------------------------------------------------------------
  // Control flow and memory issue
  //--------------------------------------------------------------------

  // Taken beq or any jal, pulses for one cycle
  assign redirect = x_valid && (is_jal || (is_beq && src_a == src_b));
  assign target   = x_pc + (is_jal ? imm_j : imm_b);

  // Data memory sees the request this cycle, data returns next cycle
  assign dmem_addr  = alu_y;
  assign dmem_we    = x_valid && is_store;
  assign dmem_wdata = src_b;

  //--------------------------------------------------------------------
  // Retire fields toward writeback
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      w_valid <= 1'b0;
      w_we    <= 1'b0;
    end else begin
      w_valid <= x_valid;
      // Writes to x0 never reach the trace as writes
      w_we    <= x_valid && rd_we && rd != '0;
    end
  end

  always_ff @(posedge clk) begin
    w_pc  <= x_pc;
    w_rd  <= rd;
    w_sel <= sel;
    w_alu <= alu_y;
  end

endmodule

`default_nettype wire

//--- hdl/writeback_stage.sv
// Result select, register write and the retire trace.
// trace_val is a one-cycle strobe; the other trace fields hold the last
// retired record between strobes and mean nothing while trace_wen is low.

`timescale 1ns/1ps
`default_nettype none

module writeback_stage
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      w_valid,
  input  word_t     w_pc,
  input  reg_addr_t w_rd,
  input  logic      w_we,
  input  wb_sel_e   w_sel,
  input  word_t     w_alu,
  input  word_t     dmem_rdata,
  output logic      rf_we,
  output reg_addr_t rf_rd,
  output word_t     rf_data,
  output logic      trace_val,
  output word_t     trace_pc,
  output reg_addr_t trace_waddr,
  output word_t     trace_wdata,
  output logic      trace_wen
);

  //--------------------------------------------------------------------
  // Result select and register write, also the execute bypass
  //--------------------------------------------------------------------

  word_t result;

  always_comb begin
    case (w_sel)
      WB_LOAD: result = dmem_rdata;
      WB_LINK: result = w_pc + 32'd4;
      default: result = w_alu;
    endcase
  end

  assign rf_we   = w_valid && w_we;
  assign rf_rd   = w_rd;
  assign rf_data = result;

  //--------------------------------------------------------------------
  // Trace, live record on the strobe, last record otherwise
  //--------------------------------------------------------------------

  word_t     held_pc;
  reg_addr_t held_rd;
  word_t     held_data;
  logic      held_wen;

  always_ff @(posedge clk) begin
    if (rst) begin
      held_wen <= 1'b0;
    end else if (w_valid) begin
      held_wen <= rf_we;
    end
  end

  always_ff @(posedge clk) begin
    if (w_valid) begin
      held_pc   <= w_pc;
      held_rd   <= w_rd;
      held_data <= result;
    end
  end

  assign trace_val   = w_valid;
  assign trace_pc    = w_valid ? w_pc   : held_pc;
  assign trace_waddr = w_valid ? w_rd   : held_rd;
  assign trace_wdata = w_valid ? result : held_data;
  assign trace_wen   = w_valid ? rf_we  : held_wen;

endmodule

`default_nettype wire

//--- hdl/core_top.sv
// Three-stage RV32I subset core with on-chip instruction and data memory.
// Load the memories with run low; load_addr is a byte address, low bits
// dropped. Raising run starts execution at the reset pc.

`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module core_top
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      run,
  input  logic      load_en,
  input  logic      load_dmem,
  input  word_t     load_addr,
  input  word_t     load_data,
  output logic      trace_val,
  output word_t     trace_pc,
  output reg_addr_t trace_waddr,
  output word_t     trace_wdata,
  output logic      trace_wen
);

  // Fetch to execute
  word_t     pc, x_pc, inst;
  logic      x_valid, redirect;
  word_t     target;
  // Execute to register file and data memory
  reg_addr_t rs1, rs2;
  word_t     rs1_data, rs2_data;
  word_t     ex_dmem_addr, ex_dmem_wdata, dmem_rdata;
  logic      ex_dmem_we;
  // Execute to writeback
  logic      w_valid, w_we;
  word_t     w_pc, w_alu;
  reg_addr_t w_rd;
  wb_sel_e   w_sel;
  // Writeback to register file and bypass
  logic      rf_we;
  reg_addr_t rf_rd;
  word_t     rf_data;

  //--------------------------------------------------------------------
  // Memory port muxing, load port owns both memories while idle
  //--------------------------------------------------------------------

  word_t imem_addr, dmem_addr, dmem_wdata;
  logic  imem_we, dmem_we;

  // Byte address to word index
  assign imem_addr  = run ? {2'b00, pc[31:2]} : {2'b00, load_addr[31:2]};
  assign imem_we    = !run && load_en && !load_dmem;
  assign dmem_addr  = run ? {2'b00, ex_dmem_addr[31:2]} : {2'b00, load_addr[31:2]};
  assign dmem_we    = run ? ex_dmem_we : (load_en && load_dmem);
  assign dmem_wdata = run ? ex_dmem_wdata : load_data;

  word_mem #(.DEPTH(`CORE_IMEM_WORDS)) u_imem (
    .clk(clk), .addr(imem_addr), .rd_data(inst), .wr_en(imem_we), .wr_data(load_data)
  );

  word_mem #(.DEPTH(`CORE_DMEM_WORDS)) u_dmem (
    .clk(clk), .addr(dmem_addr), .rd_data(dmem_rdata), .wr_en(dmem_we), .wr_data(dmem_wdata)
  );

  //--------------------------------------------------------------------
  // Pipeline
  //--------------------------------------------------------------------

  fetch_stage u_fetch (
    .clk(clk), .rst(rst), .run(run), .redirect(redirect), .target(target),
    .pc(pc), .x_valid(x_valid), .x_pc(x_pc)
  );

  regfile u_rf (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .we(rf_we), .rd(rf_rd), .rd_data(rf_data)
  );

  execute_stage u_exec (
    .clk(clk), .rst(rst), .x_valid(x_valid), .x_pc(x_pc), .inst(inst),
    .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .byp_we(rf_we), .byp_rd(rf_rd), .byp_data(rf_data),
    .dmem_addr(ex_dmem_addr), .dmem_we(ex_dmem_we), .dmem_wdata(ex_dmem_wdata),
    .redirect(redirect), .target(target),
    .w_valid(w_valid), .w_pc(w_pc), .w_rd(w_rd), .w_we(w_we), .w_sel(w_sel), .w_alu(w_alu)
  );

  writeback_stage u_wb (
    .clk(clk), .rst(rst),
    .w_valid(w_valid), .w_pc(w_pc), .w_rd(w_rd), .w_we(w_we), .w_sel(w_sel), .w_alu(w_alu),
    .dmem_rdata(dmem_rdata), .rf_we(rf_we), .rf_rd(rf_rd), .rf_data(rf_data),
    .trace_val(trace_val), .trace_pc(trace_pc), .trace_waddr(trace_waddr),
    .trace_wdata(trace_wdata), .trace_wen(trace_wen)
  );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// Free-running testbench clock, starts low at time zero.
// Period is twice HALF_PERIOD in ns, 4 ns by default.

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int HALF_PERIOD = 2
) (
  output logic clk
);

  initial clk = 1'b0;

  // Rising edges at 2, 6, 10 ns and so on
  always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

//--- test/core_ref_model.svh
// Instruction encoders and an ISA-level model of the retire trace.
// Included inside the testbench module and uses its ref_imem and ref_dmem.
// The model stops after the first jal x0,0, which serves as the halt.

`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

`include "core_config.svh"

//----------------------------------------------------------------------
// Encoders, all fields given as int and cut to width
//----------------------------------------------------------------------

function automatic word_t op_r(input int f7, input int f3, input int rd, input int rs1,
                               input int rs2);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic word_t op_i(input int opc, input int f3, input int rd, input int rs1,
                               input int imm);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

function automatic word_t op_add(input int rd, input int rs1, input int rs2);
  return op_r(0, 0, rd, rs1, rs2);
endfunction

function automatic word_t op_sub(input int rd, input int rs1, input int rs2);
  return op_r(32, 0, rd, rs1, rs2);
endfunction

function automatic word_t op_or(input int rd, input int rs1, input int rs2);
  return op_r(0, 6, rd, rs1, rs2);
endfunction

function automatic word_t op_and(input int rd, input int rs1, input int rs2);
  return op_r(0, 7, rd, rs1, rs2);
endfunction

function automatic word_t op_addi(input int rd, input int rs1, input int imm);
  return op_i('h13, 0, rd, rs1, imm);
endfunction

function automatic word_t op_lw(input int rd, input int rs1, input int imm);
  return op_i('h03, 2, rd, rs1, imm);
endfunction

// Upper 20 bits only
function automatic word_t op_lui(input int rd, input int imm20);
  return {imm20[19:0], rd[4:0], 7'b0110111};
endfunction

function automatic word_t op_sw(input int rs2, input int rs1, input int imm);
  return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

// Byte offset relative to the branch pc
function automatic word_t op_beq(input int rs1, input int rs2, input int off);
  return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], 7'b1100011};
endfunction

function automatic word_t op_jal(input int rd, input int off);
  return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
endfunction

//----------------------------------------------------------------------
// Functional model
//----------------------------------------------------------------------

// Word index with wrap onto the memory depth
function automatic int dmem_index(input word_t addr);
  return int'((addr >> 2) % `CORE_DMEM_WORDS);
endfunction

// Fills exp_* with one record per retired instruction, 1 if halt reached
function automatic bit run_model(input int max_steps);
  word_t regs [32];
  word_t pc;
  word_t nxt;
  word_t inst;
  word_t a;
  word_t b;
  word_t val;
  logic  wen;
  exp_pc.delete();
  exp_rd.delete();
  exp_data.delete();
  exp_wen.delete();
  for (int i = 0; i < 32; i++) begin
    regs[i] = '0;
  end
  pc = `CORE_RESET_PC;
  for (int n = 0; n < max_steps; n++) begin
    inst = ref_imem[int'((pc >> 2) % `CORE_IMEM_WORDS)];
    a    = regs[inst[19:15]];
    b    = regs[inst[24:20]];
    nxt  = pc + 32'd4;
    val  = '0;
    wen  = 1'b0;
    case (inst[6:0])
      7'b0110011: begin
        wen = 1'b1;
        case (inst[14:12])
          3'b000:  val = inst[30] ? a - b : a + b;
          3'b110:  val = a | b;
          3'b111:  val = a & b;
          default: wen = 1'b0;
        endcase
      end
      7'b0010011: begin
        wen = (inst[14:12] == 3'b000);
        val = a + {{20{inst[31]}}, inst[31:20]};
      end
      7'b0110111: begin
        wen = 1'b1;
        val = {inst[31:12], 12'h000};
      end
      7'b0000011: begin
        wen = (inst[14:12] == 3'b010);
        val = ref_dmem[dmem_index(a + {{20{inst[31]}}, inst[31:20]})];
      end
      7'b0100011: begin
        if (inst[14:12] == 3'b010) begin
          ref_dmem[dmem_index(a + {{20{inst[31]}}, inst[31:25], inst[11:7]})] = b;
        end
      end
      7'b1100011: begin
        if (inst[14:12] == 3'b000 && a == b) begin
          nxt = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      7'b1101111: begin
        wen = 1'b1;
        val = pc + 32'd4;
        nxt = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: ;
    endcase
    // x0 is never a visible write
    if (inst[11:7] == 5'd0) begin
      wen = 1'b0;
    end
    exp_pc.push_back(pc);
    exp_rd.push_back(inst[11:7]);
    exp_data.push_back(val);
    exp_wen.push_back(wen);
    if (wen) begin
      regs[inst[11:7]] = val;
    end
    if (inst == op_jal(0, 0)) begin
      return 1'b1;
    end
    pc = nxt;
  end
  return 1'b0;
endfunction

`endif

//--- test/core_tb.sv
// Directed tests for core_top against the included ISA model.
// Every program ends in jal x0,0; traces after the halt record are ignored.
// Memories are reloaded and the core reset before each test.

`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module core_tb
  import core_pkg::*;
();

  // Cycles allowed between two retire strobes
  localparam int TRACE_TIMEOUT = 50;

  logic      clk;
  logic      rst;
  logic      run;
  logic      load_en;
  logic      load_dmem;
  word_t     load_addr;
  word_t     load_data;
  logic      trace_val;
  word_t     trace_pc;
  reg_addr_t trace_waddr;
  word_t     trace_wdata;
  logic      trace_wen;

  int        errors;
  word_t     prog [$];
  word_t     ref_imem [`CORE_IMEM_WORDS];
  word_t     ref_dmem [`CORE_DMEM_WORDS];
  word_t     exp_pc [$];
  reg_addr_t exp_rd [$];
  word_t     exp_data [$];
  logic      exp_wen [$];

  tb_clock u_clock (.clk(clk));

  core_top DUT (
    .clk(clk), .rst(rst), .run(run),
    .load_en(load_en), .load_dmem(load_dmem), .load_addr(load_addr), .load_data(load_data),
    .trace_val(trace_val), .trace_pc(trace_pc), .trace_waddr(trace_waddr),
    .trace_wdata(trace_wdata), .trace_wen(trace_wen)
  );

  `include "core_ref_model.svh"

  //--------------------------------------------------------------------
  // Compare tasks
  //--------------------------------------------------------------------

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  //--------------------------------------------------------------------
  // Drive helpers
  //--------------------------------------------------------------------

  // Two reset cycles, then the idle state is checked
  task automatic reset_core();
    @(posedge clk);
    rst     <= 1'b1;
    run     <= 1'b0;
    load_en <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_bit("trace_val", trace_val, 1'b0);
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_bit("trace_val", trace_val, 1'b0);
    check_bit("redirect", DUT.redirect, 1'b0);
    check_bit("dmem_we", DUT.ex_dmem_we, 1'b0);
    check_bit("rf_we", DUT.rf_we, 1'b0);
    check_word("pc", DUT.pc, `CORE_RESET_PC);
  endtask

  task automatic load_word(input logic to_dmem, input int idx, input word_t data);
    @(posedge clk);
    load_en   <= 1'b1;
    load_dmem <= to_dmem;
    load_addr <= word_t'(idx) << 2;
    load_data <= data;
  endtask

  // Fill value spread over all address bits
  function automatic word_t fill_word(input int idx);
    return (word_t'(idx) * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
  endfunction

  // Program into imem, pattern into dmem, then the model's expected trace
  task automatic prepare_program(input string name);
    foreach (prog[i]) begin
      ref_imem[i] = prog[i];
      load_word(1'b0, i, prog[i]);
    end
    for (int i = 0; i < `CORE_DMEM_WORDS; i++) begin
      ref_dmem[i] = fill_word(i);
      load_word(1'b1, i, ref_dmem[i]);
    end
    @(posedge clk);
    load_en <= 1'b0;
    if (!run_model(500)) begin
      $display("Model for test %s did not reach the halt instruction", name);
      errors++;
    end
  endtask

  // Compares count records; latency of the first one in cycles after run
  task automatic collect_traces(input int count, output int first_lat);
    int waited;
    first_lat = -1;
    for (int i = 0; i < count; i++) begin
      waited = 0;
      @(negedge clk);
      while (!trace_val && waited < TRACE_TIMEOUT) begin
        waited++;
        @(negedge clk);
      end
      if (!trace_val) begin
        $display("Timeout: no retire for record %0d within %0d cycles", i, TRACE_TIMEOUT);
        errors++;
        return;
      end
      if (i == 0) begin
        first_lat = waited;
      end
      check_word($sformatf("trace_pc[%0d]", i), trace_pc, exp_pc[i]);
      check_bit($sformatf("trace_wen[%0d]", i), trace_wen, exp_wen[i]);
      // Address and data only carry meaning on a write
      if (exp_wen[i]) begin
        check_reg($sformatf("trace_waddr[%0d]", i), trace_waddr, exp_rd[i]);
        check_word($sformatf("trace_wdata[%0d]", i), trace_wdata, exp_data[i]);
      end
    end
  endtask

  task automatic run_program(input string name, output int first_lat);
    prepare_program(name);
    @(posedge clk);
    run <= 1'b1;
    collect_traces(exp_pc.size(), first_lat);
    @(posedge clk);
    run <= 1'b0;
  endtask

  //--------------------------------------------------------------------
  // Tests
  //--------------------------------------------------------------------

  task automatic test_alu();
    int lat;
    reset_core();
    prog.delete();
    prog.push_back(op_lui(1, 'h12345));
    prog.push_back(op_addi(2, 0, 'h678));
    prog.push_back(op_or(3, 1, 2));
    prog.push_back(op_addi(4, 0, -1));
    prog.push_back(op_and(5, 3, 4));
    prog.push_back(op_sub(6, 5, 2));
    prog.push_back(op_add(7, 6, 1));
    // Write to x0, then read it back
    prog.push_back(op_addi(0, 0, 5));
    prog.push_back(op_add(8, 0, 0));
    prog.push_back(op_jal(0, 0));
    run_program("alu", lat);
  endtask

  task automatic test_bypass();
    int lat;
    reset_core();
    prog.delete();
    prog.push_back(op_addi(1, 0, 1));
    prog.push_back(op_add(1, 1, 1));
    prog.push_back(op_add(1, 1, 1));
    prog.push_back(op_add(2, 1, 1));
    prog.push_back(op_sub(3, 2, 1));
    prog.push_back(op_or(4, 3, 2));
    prog.push_back(op_jal(0, 0));
    run_program("bypass", lat);
    if (lat != 2) begin
      $display("First retire came %0d cycles after run instead of 2", lat);
      errors++;
    end
  endtask

  task automatic test_load_store();
    int lat;
    reset_core();
    prog.delete();
    prog.push_back(op_addi(1, 0, 'h5a));
    prog.push_back(op_lui(2, 'hcafe0));
    prog.push_back(op_or(2, 2, 1));
    prog.push_back(op_sw(2, 0, 8));
    prog.push_back(op_lw(3, 0, 8));
    // Load-use with no gap
    prog.push_back(op_add(4, 3, 3));
    prog.push_back(op_lw(5, 0, 12));
    prog.push_back(op_add(6, 5, 1));
    prog.push_back(op_jal(0, 0));
    run_program("load_store", lat);
  endtask

  task automatic test_branch_jump();
    int lat;
    reset_core();
    prog.delete();
    prog.push_back(op_addi(1, 0, 3));
    prog.push_back(op_addi(2, 0, 3));
    // Taken, skips pc 12
    prog.push_back(op_beq(1, 2, 8));
    prog.push_back(op_addi(3, 0, 99));
    // Not taken
    prog.push_back(op_beq(1, 0, 8));
    prog.push_back(op_jal(5, 8));
    prog.push_back(op_addi(3, 0, 77));
    prog.push_back(op_add(6, 5, 1));
    prog.push_back(op_jal(0, 0));
    run_program("branch_jump", lat);
  endtask

  task automatic test_random();
    int lat;
    int kind;
    int rd;
    int rs1;
    int rs2;
    int off;
    reset_core();
    prog.delete();
    // Registers x0..x7 only, so most instructions depend on recent ones
    for (int i = 0; i < 40; i++) begin
      kind = int'($urandom_range(7, 0));
      rd   = int'($urandom_range(7, 0));
      rs1  = int'($urandom_range(7, 0));
      rs2  = int'($urandom_range(7, 0));
      off  = int'($urandom_range(15, 0)) * 4;
      case (kind)
        0: prog.push_back(op_add(rd, rs1, rs2));
        1: prog.push_back(op_sub(rd, rs1, rs2));
        2: prog.push_back(op_and(rd, rs1, rs2));
        3: prog.push_back(op_or(rd, rs1, rs2));
        4: prog.push_back(op_addi(rd, rs1, int'($urandom_range(4095, 0)) - 2048));
        5: prog.push_back(op_lui(rd, int'($urandom)));
        6: prog.push_back(op_lw(rd, 0, off));
        default: prog.push_back(op_sw(rs2, 0, off));
      endcase
    end
    prog.push_back(op_jal(0, 0));
    run_program("random", lat);
  endtask

  task automatic test_mid_reset();
    int lat;
    reset_core();
    prog.delete();
    prog.push_back(op_addi(1, 0, 10));
    prog.push_back(op_addi(2, 1, 20));
    prog.push_back(op_add(3, 2, 1));
    prog.push_back(op_sub(4, 3, 2));
    prog.push_back(op_or(5, 4, 3));
    prog.push_back(op_lui(6, 'h0f0f0));
    prog.push_back(op_and(7, 6, 5));
    prog.push_back(op_jal(0, 0));
    prepare_program("mid_reset");
    @(posedge clk);
    run <= 1'b1;
    collect_traces(3, lat);
    // Cut the program short, same memories on restart
    reset_core();
    @(posedge clk);
    run <= 1'b1;
    collect_traces(exp_pc.size(), lat);
    @(posedge clk);
    run <= 1'b0;
    if (lat != 2) begin
      $display("First retire after reset came %0d cycles after run instead of 2", lat);
      errors++;
    end
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------

  initial begin
    rst       = 1'b1;
    run       = 1'b0;
    load_en   = 1'b0;
    load_dmem = 1'b0;
    load_addr = '0;
    load_data = '0;
    errors    = 0;
    void'($urandom(38));
    test_alu();
    test_bypass();
    test_load_store();
    test_branch_jump();
    test_random();
    test_mid_reset();
    $display("Summary: 6 tests run, %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
+incdir+test
hdl/core_pkg.sv
hdl/word_mem.sv
hdl/regfile.sv
hdl/fetch_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/core_top.sv
test/tb_clock.sv
test/core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it, then scan the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f --top-module core_tb \
  --Mdir obj_dir -o core_sim

./obj_dir/core_sim | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "Failure reported in sim.log"
  exit 1
fi

echo "No failure reported in sim.log"
